// ==== bulk_in_bridge.f ====
rtl/bulk_in_pkg.sv
rtl/endpoint_scheduler.sv
rtl/telemetry_recorder.sv
rtl/in_stream_mux.sv
rtl/bulk_in_bridge.sv
sim/bulk_in_checker.sv
sim/bulk_in_bridge_tb.sv

// ==== rtl/bulk_in_bridge.sv ====
module bulk_in_bridge
  import bulk_in_pkg::*;
(
  input  logic       clock,
  input  logic       areset_n,
  input  logic       usb_reset_i,
  input  logic       high_speed_i,
  input  logic [3:0] blk_endpt_i,
  input  logic       blk_start_i,
  input  logic       blk_fetch_i,
  input  logic       blk_in_ready_i,
  input  logic [1:0] line_state_i,
  input  logic [3:0] usb_state_i,
  input  logic [2:0] err_code_i,
  input  logic [3:0] ctl_state_i,
  input  logic [3:0] phy_state_i,
  input  logic [3:0] tok_endp_i,
  input  logic       tok_recv_i,
  input  logic       sof_i,
  input  logic       crc_error_i,
  input  logic       timeout_i,
  input  logic       hsk_sent_i,
  input  logic       usb_recv_i,
  input  logic       usb_sent_i,
  input  logic       s_axis_tvalid_i,
  output logic       s_axis_tready_o,
  input  logic       s_axis_tlast_i,
  input  logic       s_axis_tkeep_i,
  input  logic [7:0] s_axis_tdata_i,
  output logic       tx_tvalid_o,
  input  logic       tx_tready_i,
  output logic       tx_tlast_o,
  output logic       tx_tkeep_o,
  output logic [7:0] tx_tdata_o,
  output logic       reset_o,
  output logic       blk_in_ready_o,
  output logic       has_telemetry_o
);

  logic                       tele_sel;
  logic [TELE_LEVEL_BITS-1:0] tele_level;
  logic                       tel_tvalid;
  logic                       tel_tready;
  logic                       tel_tlast;
  logic [7:0]                 tel_tdata;

  endpoint_scheduler u_sched (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_reset_i     (usb_reset_i),
    .high_speed_i    (high_speed_i),
    .blk_endpt_i     (blk_endpt_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .tele_level_i    (tele_level),
    .reset_o         (reset_o),
    .tele_sel_o      (tele_sel),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o)
  );

  telemetry_recorder u_tele (
    .clock        (clock),
    .reset_i      (reset_o),
    .tele_sel_i   (tele_sel),
    .blk_start_i  (blk_start_i),
    .line_state_i (line_state_i),
    .usb_state_i  (usb_state_i),
    .err_code_i   (err_code_i),
    .ctl_state_i  (ctl_state_i),
    .phy_state_i  (phy_state_i),
    .tok_endp_i   (tok_endp_i),
    .tok_recv_i   (tok_recv_i),
    .sof_i        (sof_i),
    .crc_error_i  (crc_error_i),
    .timeout_i    (timeout_i),
    .hsk_sent_i   (hsk_sent_i),
    .usb_recv_i   (usb_recv_i),
    .usb_sent_i   (usb_sent_i),
    .tele_level_o (tele_level),
    .tel_tvalid_o (tel_tvalid),
    .tel_tready_i (tel_tready),
    .tel_tlast_o  (tel_tlast),
    .tel_tdata_o  (tel_tdata)
  );

  in_stream_mux u_mux (
    .clock           (clock),
    .reset_i         (reset_o),
    .tele_sel_i      (tele_sel),
    .blk_fetch_i     (blk_fetch_i),
    .s_axis_tvalid_i (s_axis_tvalid_i),
    .s_axis_tready_o (s_axis_tready_o),
    .s_axis_tlast_i  (s_axis_tlast_i),
    .s_axis_tkeep_i  (s_axis_tkeep_i),
    .s_axis_tdata_i  (s_axis_tdata_i),
    .tel_tvalid_i    (tel_tvalid),
    .tel_tready_o    (tel_tready),
    .tel_tlast_i     (tel_tlast),
    .tel_tdata_i     (tel_tdata),
    .tx_tvalid_o     (tx_tvalid_o),
    .tx_tready_i     (tx_tready_i),
    .tx_tlast_o      (tx_tlast_o),
    .tx_tkeep_o      (tx_tkeep_o),
    .tx_tdata_o      (tx_tdata_o)
  );

endmodule

// ==== rtl/bulk_in_pkg.sv ====
package bulk_in_pkg;

  // Bulk-IN endpoint numbers
  localparam logic [3:0] ENDPOINT_USER = 4'd1;
  localparam logic [3:0] ENDPOINT_TELE = 4'd2;

  // Telemetry FIFO sizing, all in 32-bit words
  localparam int TELE_FIFO_WORDS    = 32;
  localparam int TELE_LEVEL_BITS    = 6;  // Holds 0 to TELE_FIFO_WORDS
  localparam int TELE_PACKET_WORDS  = 8;  // One bulk packet of 32 bytes
  localparam int TELE_PRESENT_WORDS = 4;

  // Status word as captured from the bus, MSB first
  typedef struct packed {
    logic [1:0] line_state;
    logic [3:0] usb_state;
    logic [2:0] err_code;
    logic       tok_recv;
    logic       sof;
    logic       crc_error;
    logic       timeout;
    logic       hsk_sent;
    logic       usb_recv;
    logic       usb_sent;
    logic [3:0] ctl_state;
    logic [3:0] phy_state;
    logic [3:0] endpt;
    logic [3:0] spare;  // Always zero
  } telemetry_fields_t;

  // Same word, seen as the bytes sent to the host, byte 0 is the LSB
  typedef union packed {
    telemetry_fields_t   fields;
    logic [3:0][7:0]     bytes;
  } telemetry_word_t;

endpackage

// ==== rtl/endpoint_scheduler.sv ====
module endpoint_scheduler
  import bulk_in_pkg::*;
(
  input  logic                       clock,
  input  logic                       areset_n,
  input  logic                       usb_reset_i,
  input  logic                       high_speed_i,
  input  logic [3:0]                 blk_endpt_i,
  input  logic                       blk_in_ready_i,
  input  logic [TELE_LEVEL_BITS-1:0] tele_level_i,
  output logic                       reset_o,
  output logic                       tele_sel_o,
  output logic                       blk_in_ready_o,
  output logic                       has_telemetry_o
);

  logic [3:0] rst_n_q;  // Stage 3 releases the core reset
  logic       tele_sel_q;
  logic       blk_in_ready_q;

  // Release takes four edges, a bus reset pulls the last stage low again
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rst_n_q <= 4'h0;
    end else begin
      rst_n_q <= {rst_n_q[2] & ~usb_reset_i, rst_n_q[1:0], 1'b1};
    end
  end

  assign reset_o = ~rst_n_q[3];

  always_ff @(posedge clock) begin
    if (reset_o) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_q <= 1'b0;
    end else begin
      tele_sel_q <= blk_endpt_i == ENDPOINT_TELE;

      if (!high_speed_i) begin
        blk_in_ready_q <= 1'b0;
      end else if (blk_endpt_i == ENDPOINT_USER && blk_in_ready_i) begin
        blk_in_ready_q <= 1'b1;
      end else if (blk_endpt_i == ENDPOINT_TELE && tele_level_i >= TELE_PACKET_WORDS) begin
        blk_in_ready_q <= 1'b1;  // A full packet is waiting
      end else begin
        blk_in_ready_q <= 1'b0;
      end
    end
  end

  assign tele_sel_o      = tele_sel_q;
  assign blk_in_ready_o  = blk_in_ready_q;
  assign has_telemetry_o = tele_level_i >= TELE_PRESENT_WORDS;

endmodule

// ==== rtl/in_stream_mux.sv ====
module in_stream_mux (
  input  logic       clock,
  input  logic       reset_i,
  input  logic       tele_sel_i,
  input  logic       blk_fetch_i,
  input  logic       s_axis_tvalid_i,
  output logic       s_axis_tready_o,
  input  logic       s_axis_tlast_i,
  input  logic       s_axis_tkeep_i,
  input  logic [7:0] s_axis_tdata_i,
  input  logic       tel_tvalid_i,
  output logic       tel_tready_o,
  input  logic       tel_tlast_i,
  input  logic [7:0] tel_tdata_i,
  output logic       tx_tvalid_o,
  input  logic       tx_tready_i,
  output logic       tx_tlast_o,
  output logic       tx_tkeep_o,
  output logic [7:0] tx_tdata_o
);

  logic       mux_valid;
  logic [9:0] mux_beat;   // {last, keep, data}
  logic       in_fire;
  logic       out_free;

  logic       in_ready_q;
  logic       out_valid_q;
  logic [9:0] out_beat_q;
  logic       skid_valid_q;
  logic [9:0] skid_beat_q;
  logic       out_valid_d;
  logic       skid_valid_d;

  // Telemetry wins when selected, user bytes only during a fetch
  assign mux_valid = tele_sel_i ? tel_tvalid_i : blk_fetch_i & s_axis_tvalid_i;
  assign mux_beat  = tele_sel_i ? {tel_tlast_i, 1'b1, tel_tdata_i}
                                : {s_axis_tlast_i, s_axis_tkeep_i, s_axis_tdata_i};

  assign tel_tready_o    = tele_sel_i & in_ready_q;
  assign s_axis_tready_o = ~tele_sel_i & blk_fetch_i & in_ready_q;

  assign in_fire  = mux_valid & in_ready_q;
  assign out_free = ~out_valid_q | tx_tready_i;  // Output slot empties this edge

  always_comb begin
    out_valid_d  = out_valid_q;
    skid_valid_d = skid_valid_q;
    if (out_free) begin
      out_valid_d  = skid_valid_q | in_fire;
      skid_valid_d = skid_valid_q & in_fire;
    end else if (in_fire) begin
      skid_valid_d = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (out_free) begin
      out_beat_q <= skid_valid_q ? skid_beat_q : mux_beat;
    end
    if (in_fire && (skid_valid_q || !out_free)) begin
      skid_beat_q <= mux_beat;  // Held behind the output slot
    end
  end

  always_ff @(posedge clock) begin
    if (reset_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready_q   <= 1'b1;
    end else begin
      out_valid_q  <= out_valid_d;
      skid_valid_q <= skid_valid_d;
      in_ready_q   <= ~(out_valid_d & skid_valid_d);
    end
  end

  assign tx_tvalid_o = out_valid_q;
  assign tx_tlast_o  = out_beat_q[9];
  assign tx_tkeep_o  = out_beat_q[8];
  assign tx_tdata_o  = out_beat_q[7:0];

endmodule

// ==== rtl/telemetry_recorder.sv ====
module telemetry_recorder
  import bulk_in_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset_i,
  input  logic                       tele_sel_i,
  input  logic                       blk_start_i,
  input  logic [1:0]                 line_state_i,
  input  logic [3:0]                 usb_state_i,
  input  logic [2:0]                 err_code_i,
  input  logic [3:0]                 ctl_state_i,
  input  logic [3:0]                 phy_state_i,
  input  logic [3:0]                 tok_endp_i,
  input  logic                       tok_recv_i,
  input  logic                       sof_i,
  input  logic                       crc_error_i,
  input  logic                       timeout_i,
  input  logic                       hsk_sent_i,
  input  logic                       usb_recv_i,
  input  logic                       usb_sent_i,
  output logic [TELE_LEVEL_BITS-1:0] tele_level_o,
  output logic                       tel_tvalid_o,
  input  logic                       tel_tready_i,
  output logic                       tel_tlast_o,
  output logic [7:0]                 tel_tdata_o
);

  telemetry_word_t fifo_mem [TELE_FIFO_WORDS];

  logic [$clog2(TELE_FIFO_WORDS)-1:0]   wr_ptr_q;
  logic [$clog2(TELE_FIFO_WORDS)-1:0]   rd_ptr_q;
  logic [TELE_LEVEL_BITS-1:0]           level_q;
  logic [$clog2(TELE_PACKET_WORDS)-1:0] word_cnt_q;  // Words sent in this packet
  logic [1:0]                           byte_idx_q;
  logic                                 busy_q;      // Packet in flight

  telemetry_word_t cap_word;
  telemetry_word_t rd_word;
  logic            event_any;
  logic            push;
  logic            pop;
  logic            beat;

  assign event_any = tok_recv_i | sof_i | crc_error_i | timeout_i |
                     hsk_sent_i | usb_recv_i | usb_sent_i;
  assign push      = event_any && level_q != TELE_FIFO_WORDS;  // Dropped when full

  always_comb begin
    cap_word.fields.line_state = line_state_i;
    cap_word.fields.usb_state  = usb_state_i;
    cap_word.fields.err_code   = err_code_i;
    cap_word.fields.tok_recv   = tok_recv_i;
    cap_word.fields.sof        = sof_i;
    cap_word.fields.crc_error  = crc_error_i;
    cap_word.fields.timeout    = timeout_i;
    cap_word.fields.hsk_sent   = hsk_sent_i;
    cap_word.fields.usb_recv   = usb_recv_i;
    cap_word.fields.usb_sent   = usb_sent_i;
    cap_word.fields.ctl_state  = ctl_state_i;
    cap_word.fields.phy_state  = phy_state_i;
    cap_word.fields.endpt      = tok_endp_i;
    cap_word.fields.spare      = 4'h0;
  end

  always_ff @(posedge clock) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= cap_word;
    end
  end

  // Serialise the head word, byte 0 first
  assign rd_word      = fifo_mem[rd_ptr_q];
  assign tel_tvalid_o = busy_q;
  assign tel_tdata_o  = rd_word.bytes[byte_idx_q];
  assign tel_tlast_o  = busy_q && byte_idx_q == 2'd3 && word_cnt_q == TELE_PACKET_WORDS - 1;

  assign beat = busy_q && tel_tready_i;
  assign pop  = beat && byte_idx_q == 2'd3;  // Word retires with its byte 3

  always_ff @(posedge clock) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      word_cnt_q <= '0;
      byte_idx_q <= 2'd0;
      busy_q     <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase

      if (!busy_q) begin
        // Only arm when a whole packet is already held
        if (blk_start_i && tele_sel_i && level_q >= TELE_PACKET_WORDS) begin
          busy_q     <= 1'b1;
          byte_idx_q <= 2'd0;
          word_cnt_q <= '0;
        end
      end else if (beat) begin
        byte_idx_q <= byte_idx_q + 1'b1;
        if (byte_idx_q == 2'd3) begin
          word_cnt_q <= word_cnt_q + 1'b1;
          if (tel_tlast_o) begin
            busy_q <= 1'b0;
          end
        end
      end
    end
  end

  assign tele_level_o = level_q;

endmodule

// ==== sim/bulk_in_bridge_tb.sv ====
module bulk_in_bridge_tb
  import bulk_in_pkg::*;
();

  typedef enum int {RESET_ROW, USER_ROW, EVENTS_ROW, PACKET_ROW, READY_ROW} row_kind_e;

  logic clock, areset_n, usb_reset_i, high_speed_i, blk_start_i, blk_fetch_i;
  logic blk_in_ready_i, s_axis_tvalid_i, s_axis_tlast_i, s_axis_tkeep_i, tx_tready_i;
  logic [3:0] blk_endpt_i, usb_state_i, ctl_state_i, phy_state_i, tok_endp_i;
  logic [1:0] line_state_i;
  logic [2:0] err_code_i;
  logic [6:0] strobes;
  logic [7:0] s_axis_tdata_i, tx_tdata_o;
  logic s_axis_tready_o, tx_tvalid_o, tx_tlast_o, tx_tkeep_o;
  logic reset_o, blk_in_ready_o, has_telemetry_o;

  string     names[$];
  row_kind_e kinds[$];
  int        counts[$];
  bit        bps[$];
  logic [7:0] exps[$];
  logic [31:0] rng = 32'h6201;
  logic [31:0] bp_rng = 32'h6201;
  bit        bp_on = 1'b0;
  int        cycles = 0;
  int        limit = 0;

  bulk_in_bridge uut (
    .clock(clock), .areset_n(areset_n), .usb_reset_i(usb_reset_i),
    .high_speed_i(high_speed_i), .blk_endpt_i(blk_endpt_i), .blk_start_i(blk_start_i),
    .blk_fetch_i(blk_fetch_i), .blk_in_ready_i(blk_in_ready_i),
    .line_state_i(line_state_i), .usb_state_i(usb_state_i), .err_code_i(err_code_i),
    .ctl_state_i(ctl_state_i), .phy_state_i(phy_state_i), .tok_endp_i(tok_endp_i),
    .tok_recv_i(strobes[6]), .sof_i(strobes[5]), .crc_error_i(strobes[4]),
    .timeout_i(strobes[3]), .hsk_sent_i(strobes[2]), .usb_recv_i(strobes[1]),
    .usb_sent_i(strobes[0]), .s_axis_tvalid_i(s_axis_tvalid_i),
    .s_axis_tready_o(s_axis_tready_o), .s_axis_tlast_i(s_axis_tlast_i),
    .s_axis_tkeep_i(s_axis_tkeep_i), .s_axis_tdata_i(s_axis_tdata_i),
    .tx_tvalid_o(tx_tvalid_o), .tx_tready_i(tx_tready_i), .tx_tlast_o(tx_tlast_o),
    .tx_tkeep_o(tx_tkeep_o), .tx_tdata_o(tx_tdata_o), .reset_o(reset_o),
    .blk_in_ready_o(blk_in_ready_o), .has_telemetry_o(has_telemetry_o)
  );

  bulk_in_checker chk (
    .clock(clock), .reset_i(reset_o), .blk_endpt_i(blk_endpt_i), .blk_start_i(blk_start_i),
    .line_state_i(line_state_i), .usb_state_i(usb_state_i), .err_code_i(err_code_i),
    .ctl_state_i(ctl_state_i), .phy_state_i(phy_state_i), .tok_endp_i(tok_endp_i),
    .strobes_i(strobes), .s_axis_tvalid_i(s_axis_tvalid_i),
    .s_axis_tready_i(s_axis_tready_o), .s_axis_tlast_i(s_axis_tlast_i),
    .s_axis_tkeep_i(s_axis_tkeep_i), .s_axis_tdata_i(s_axis_tdata_i),
    .tx_tvalid_i(tx_tvalid_o), .tx_tready_i(tx_tready_i), .tx_tlast_i(tx_tlast_o),
    .tx_tkeep_i(tx_tkeep_o), .tx_tdata_i(tx_tdata_o)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic add_row(input string n, input row_kind_e k, input int c, input bit b,
                         input logic [7:0] e);
    names.push_back(n);
    kinds.push_back(k);
    counts.push_back(c);
    bps.push_back(b);
    exps.push_back(e);
  endtask

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // Random tx back-pressure while a row asks for it
  initial begin
    forever begin
      @(negedge clock);
      bp_rng = xorshift(bp_rng);
      tx_tready_i = bp_on ? bp_rng[3] : 1'b1;
    end
  end

  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing the test table", limit);
    $display("TEST FAILED");
    $finish;
  end

  task automatic wait_drained();
    while (chk.pending() != 0 || tx_tvalid_o) @(negedge clock);
    bp_on = 1'b0;
  endtask

  task automatic reset_row(input int edges_exp, input logic [7:0] exp);
    int edges;
    edges = 0;
    if (edges_exp > 0) begin
      areset_n = 1'b0;
      repeat (4) @(negedge clock);
      areset_n = 1'b1;
      while (reset_o) begin
        @(posedge clock);
        edges++;
        @(negedge clock);
      end
      chk.check_value(edges_exp, edges);
    end else begin
      usb_reset_i = 1'b1;  // Bus reset forces the core back into reset
      @(negedge clock);
      chk.check_value(1, reset_o);
      usb_reset_i = 1'b0;
      while (reset_o) @(negedge clock);
      @(negedge clock);
    end
    chk.check_value(exp, {tx_tvalid_o, blk_in_ready_o, has_telemetry_o});
  endtask

  task automatic user_row(input int count, input bit bp);
    blk_endpt_i = ENDPOINT_USER;
    blk_fetch_i = 1'b1;
    bp_on = bp;
    for (int i = 0; i < count; i++) begin
      rng = xorshift(rng);
      s_axis_tvalid_i = 1'b1;
      s_axis_tdata_i  = rng[7:0];
      s_axis_tkeep_i  = rng[8];
      s_axis_tlast_i  = i == count - 1;
      do @(posedge clock); while (!s_axis_tready_o);
      @(negedge clock);
    end
    s_axis_tvalid_i = 1'b0;
    s_axis_tlast_i  = 1'b0;
    wait_drained();
    blk_fetch_i = 1'b0;
  endtask

  task automatic flags_row(input logic [3:0] endpt, input logic [7:0] exp);
    blk_endpt_i = endpt;
    repeat (2) @(negedge clock);
    chk.check_value(exp, {has_telemetry_o, blk_in_ready_o});
  endtask

  task automatic events_row(input int count, input logic [7:0] exp);
    for (int i = 0; i < count; i++) begin
      rng = xorshift(rng);
      {line_state_i, usb_state_i, err_code_i, ctl_state_i, phy_state_i, tok_endp_i} =
        rng[20:0];
      strobes = rng[27:21] == 7'h0 ? 7'h40 : rng[27:21];
      @(negedge clock);
    end
    strobes = 7'h0;
    flags_row(ENDPOINT_TELE, exp);
  endtask

  task automatic packet_row(input bit bp, input logic [7:0] exp);
    blk_endpt_i = ENDPOINT_TELE;
    blk_fetch_i = 1'b1;
    s_axis_tvalid_i = 1'b1;  // User bytes waiting must stay blocked
    bp_on = bp;
    repeat (2) @(negedge clock);
    blk_start_i = 1'b1;
    @(negedge clock);
    blk_start_i = 1'b0;
    wait_drained();
    s_axis_tvalid_i = 1'b0;
    blk_fetch_i = 1'b0;
    flags_row(ENDPOINT_TELE, exp);
  endtask

  initial begin
    int total;
    areset_n = 1'b0;
    usb_reset_i = 1'b0;
    high_speed_i = 1'b1;
    blk_endpt_i = ENDPOINT_USER;
    {blk_start_i, blk_fetch_i, blk_in_ready_i} = 3'b000;
    {s_axis_tvalid_i, s_axis_tlast_i, s_axis_tkeep_i, s_axis_tdata_i} = 11'h0;
    {line_state_i, usb_state_i, err_code_i, ctl_state_i, phy_state_i, tok_endp_i} = 21'h0;
    strobes = 7'h0;
    tx_tready_i = 1'b1;
    add_row("por_release", RESET_ROW, 4, 0, 8'h0);
    add_row("user_free", USER_ROW, 20, 0, 8'h0);
    add_row("user_backpressure", USER_ROW, 24, 1, 8'h0);
    add_row("events_to_3", EVENTS_ROW, 3, 0, 8'b00);
    add_row("events_to_4", EVENTS_ROW, 1, 0, 8'b10);
    add_row("events_to_7", EVENTS_ROW, 3, 0, 8'b10);
    add_row("events_to_8", EVENTS_ROW, 1, 0, 8'b11);
    add_row("tele_packet", PACKET_ROW, 8, 1, 8'b00);
    add_row("ready_user", READY_ROW, 1, 0, 8'b01);
    add_row("events_overflow", EVENTS_ROW, 40, 0, 8'b11);
    add_row("tele_packet_oldest", PACKET_ROW, 8, 1, 8'b11);
    add_row("bus_reset", RESET_ROW, 0, 0, 8'h0);
    add_row("user_after_reset", USER_ROW, 16, 1, 8'h0);
    total = 0;
    foreach (counts[r]) total += counts[r];
    limit = total * 8 + 200;
    foreach (names[r]) begin
      chk.start_test(names[r]);
      case (kinds[r])
        RESET_ROW:  reset_row(counts[r], exps[r]);
        USER_ROW:   user_row(counts[r], bps[r]);
        EVENTS_ROW: events_row(counts[r], exps[r]);
        PACKET_ROW: packet_row(bps[r], exps[r]);
        default: begin
          blk_in_ready_i = 1'b1;
          flags_row(ENDPOINT_USER, exps[r]);
          blk_in_ready_i = 1'b0;
        end
      endcase
      chk.end_test();
    end
    chk.report_counts();
    if (chk.errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/bulk_in_checker.sv ====
module bulk_in_checker
  import bulk_in_pkg::*;
(
  input logic       clock,
  input logic       reset_i,
  input logic [3:0] blk_endpt_i,
  input logic       blk_start_i,
  input logic [1:0] line_state_i,
  input logic [3:0] usb_state_i,
  input logic [2:0] err_code_i,
  input logic [3:0] ctl_state_i,
  input logic [3:0] phy_state_i,
  input logic [3:0] tok_endp_i,
  input logic [6:0] strobes_i,  // tok_recv down to usb_sent
  input logic       s_axis_tvalid_i,
  input logic       s_axis_tready_i,
  input logic       s_axis_tlast_i,
  input logic       s_axis_tkeep_i,
  input logic [7:0] s_axis_tdata_i,
  input logic       tx_tvalid_i,
  input logic       tx_tready_i,
  input logic       tx_tlast_i,
  input logic       tx_tkeep_i,
  input logic [7:0] tx_tdata_i
);

  telemetry_word_t words_q[$];  // Words the recorder should hold
  logic [9:0]      beats_q[$];  // {last, keep, data} still due on tx
  logic            sel_q = 1'b0;
  int              test_errs = 0;
  int              errors = 0;
  int              passed = 0;
  int              failed = 0;
  string           test_name = "";

  function automatic int pending();
    return beats_q.size();
  endfunction

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic flag_error(input string what);
    $display("ERROR %s %s", test_name, what);
    test_errs++;
    errors++;
  endtask

  task automatic check_value(input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s expected %0h actual %0h", test_name, exp, act);
      test_errs++;
      errors++;
    end
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      passed++;
      $display("ok    %s", test_name);
    end else begin
      failed++;
      $display("fail  %s with %0d errors", test_name, test_errs);
    end
  endtask

  task automatic report_counts();
    $display("Tests %0d, passed %0d, failed %0d, errors %0d",
             passed + failed, passed, failed, errors);
  endtask

  always @(posedge clock) begin
    telemetry_word_t w;
    logic [9:0]      exp;
    int              lvl;
    lvl = words_q.size();
    if (reset_i !== 1'b0) begin
      words_q.delete();
      beats_q.delete();
      sel_q = 1'b0;
    end else begin
      if (sel_q && s_axis_tready_i) begin
        flag_error("user stream was ready while telemetry was selected");
      end
      if (tx_tvalid_i && tx_tready_i) begin
        if (beats_q.size() == 0) begin
          flag_error("tx sent a byte that was never offered");
        end else begin
          exp = beats_q.pop_front();
          check_value(exp, {tx_tlast_i, tx_tkeep_i, tx_tdata_i});
        end
      end
      if (s_axis_tvalid_i && s_axis_tready_i) begin
        beats_q.push_back({s_axis_tlast_i, s_axis_tkeep_i, s_axis_tdata_i});
      end
      // One packet of the oldest words, byte 0 first
      if (blk_start_i && sel_q && lvl >= TELE_PACKET_WORDS) begin
        for (int i = 0; i < TELE_PACKET_WORDS; i++) begin
          w = words_q.pop_front();
          for (int b = 0; b < 4; b++) begin
            beats_q.push_back({i == TELE_PACKET_WORDS - 1 && b == 3, 1'b1, w.bytes[b]});
          end
        end
      end
      if (strobes_i != 7'h0 && lvl < TELE_FIFO_WORDS) begin
        w.fields.line_state = line_state_i;
        w.fields.usb_state  = usb_state_i;
        w.fields.err_code   = err_code_i;
        w.fields.tok_recv   = strobes_i[6];
        w.fields.sof        = strobes_i[5];
        w.fields.crc_error  = strobes_i[4];
        w.fields.timeout    = strobes_i[3];
        w.fields.hsk_sent   = strobes_i[2];
        w.fields.usb_recv   = strobes_i[1];
        w.fields.usb_sent   = strobes_i[0];
        w.fields.ctl_state  = ctl_state_i;
        w.fields.phy_state  = phy_state_i;
        w.fields.endpt      = tok_endp_i;
        w.fields.spare      = 4'h0;
        words_q.push_back(w);
      end
      sel_q = blk_endpt_i == ENDPOINT_TELE;
    end
  end

endmodule
